// File: Makefile
TOP := ets_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: hw/ets_credit_tx.sv
`timescale 1ns/1ps
`include "ets_defs.svh"

module ets_credit_tx (
	input  logic                      sys_clk,
	input  logic                      rst_n,
	input  logic                      send,
	input  logic [`ETS_PHASE_W-1:0]   phase,
	input  logic [`ETS_COUNT_W-1:0]   hit_count,
	input  logic                      credit_ret,
	output logic                      ready,
	output logic                      result_valid,
	output ets_meas_pkg::ets_result_t result
);
	import ets_meas_pkg::*;

	localparam int CRED_W = $clog2(`ETS_CREDITS + 1);

	logic [CRED_W-1:0] credits; // free slots at the sink

	assign ready = (credits != '0);

	//////////////////////////////
	// credit bookkeeping
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			credits <= CRED_W'(`ETS_CREDITS); // full grant
		end else begin
			case ({send, credit_ret})
				2'b10:   credits <= credits - 1'b1; // spent
				2'b01:   credits <= credits + 1'b1; // returned
				default: ;                          // both or neither
			endcase
		end
	end

	//////////////////////////////
	// result register
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			result       <= '0;
		end else begin
			result_valid <= send; // one-cycle pulse
			if (send)
				result <= ets_result_t'{phase: phase, count: hit_count};
		end
	end

endmodule

// File: hw/ets_defs.svh
`ifndef ETS_DEFS_SVH
`define ETS_DEFS_SVH

//////////////////////////////
// widths
`define ETS_COUNT_W     16 // window length and hit count
`define ETS_PHASE_W     8  // step count and phase index
`define ETS_REG_ADDR_W  3
`define ETS_DATA_W      32
`define ETS_CREDITS     4  // sink grant after reset

//////////////////////////////
// register map
`define ETS_REG_CTRL    3'd0 // bit 0 starts a sweep
`define ETS_REG_CHANNEL 3'd1
`define ETS_REG_WINDOW  3'd2
`define ETS_REG_STEPS   3'd3
`define ETS_REG_STATUS  3'd4 // read only
`define ETS_REG_COUNT   3'd5 // read only

`endif

// File: hw/ets_hit_counter.sv
`timescale 1ns/1ps
`include "ets_defs.svh"

module ets_hit_counter (
	input  logic                    sys_clk,
	input  logic                    rst_n,
	input  logic                    cmp_ref,
	input  logic                    cmp_s11,
	input  logic                    cmp_s21,
	input  ets_meas_pkg::cmp_sel_t  channel,
	input  logic                    active,
	input  logic                    load,
	output logic [`ETS_COUNT_W-1:0] hit_count
);
	import ets_meas_pkg::*;

	logic sel_bit; // muxed comparator
	logic sel_q;   // one cycle behind the pins

	//////////////////////////////
	// comparator select
	always_comb begin
		case (channel)
			CMP_S11:     sel_bit = cmp_s11;
			CMP_S21:     sel_bit = cmp_s21;
			CMP_REF,
			CMP_REF_ALT: sel_bit = cmp_ref; // code 3 falls back to ref
			default:     sel_bit = cmp_ref;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		sel_q <= sel_bit;
	end

	//////////////////////////////
	// ones count over the window
	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			hit_count <= '0;
		else if (load)
			hit_count <= '0; // new window
		else if (active)
			hit_count <= hit_count + `ETS_COUNT_W'(sel_q);
	end

endmodule

// File: hw/ets_meas_pkg.sv
`include "ets_defs.svh"

package ets_meas_pkg;

	//////////////////////////////
	// comparator input select
	typedef enum logic [1:0] {
		CMP_REF     = 2'd0,
		CMP_S11     = 2'd1,
		CMP_S21     = 2'd2,
		CMP_REF_ALT = 2'd3 // spare code, also the reference
	} cmp_sel_t;

	//////////////////////////////
	// one record per phase step
	typedef struct packed {
		logic [`ETS_PHASE_W-1:0] phase; // step index
		logic [`ETS_COUNT_W-1:0] count; // ones seen in the window
	} ets_result_t;

	// sweep progress, as read from STATUS
	typedef struct packed {
		logic                    busy;  // sweep running
		logic [`ETS_PHASE_W-1:0] phase; // current step
	} ets_status_t;

endpackage

// File: hw/ets_reg_pkg.sv
`include "ets_defs.svh"

package ets_reg_pkg;

	// host write, no back-pressure
	typedef struct packed {
		logic                       valid;
		logic [`ETS_REG_ADDR_W-1:0] addr;
		logic [`ETS_DATA_W-1:0]     data;
	} reg_wr_t;

	// host read request
	typedef struct packed {
		logic                       valid;
		logic [`ETS_REG_ADDR_W-1:0] addr;
	} reg_rd_req_t;

	// read response, one cycle after the request
	typedef struct packed {
		logic                   valid;
		logic [`ETS_DATA_W-1:0] data;
	} reg_rd_rsp_t;

endpackage

// File: hw/ets_regs.sv
`timescale 1ns/1ps
`include "ets_defs.svh"

module ets_regs (
	input  logic                        sys_clk,
	input  logic                        rst_n,
	input  ets_reg_pkg::reg_wr_t        reg_wr,
	input  ets_reg_pkg::reg_rd_req_t    reg_rd_req,
	output ets_reg_pkg::reg_rd_rsp_t    reg_rd_rsp,
	input  ets_meas_pkg::ets_status_t   status,
	input  logic [`ETS_COUNT_W-1:0]     last_count,
	output logic                        start,
	output ets_meas_pkg::cmp_sel_t      channel,
	output logic [`ETS_COUNT_W-1:0]     window_len,
	output logic [`ETS_PHASE_W-1:0]     num_steps
);
	import ets_reg_pkg::*;
	import ets_meas_pkg::*;

	logic [`ETS_DATA_W-1:0] rd_data;    // read mux output
	logic                   rsp_valid_q;
	logic [`ETS_DATA_W-1:0] rsp_data_q;

	// CTRL is a strobe, nothing is stored
	assign start = reg_wr.valid && (reg_wr.addr == `ETS_REG_CTRL) && reg_wr.data[0];

	//////////////////////////////
	// configuration writes
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			channel    <= CMP_REF;
			window_len <= `ETS_COUNT_W'(1); // shortest legal window
			num_steps  <= '0;
		end else if (reg_wr.valid) begin
			case (reg_wr.addr)
				`ETS_REG_CHANNEL: channel    <= cmp_sel_t'(reg_wr.data[1:0]);
				`ETS_REG_WINDOW:  window_len <= reg_wr.data[`ETS_COUNT_W-1:0];
				`ETS_REG_STEPS:   num_steps  <= reg_wr.data[`ETS_PHASE_W-1:0];
				default: ; // unmapped or read only
			endcase
		end
	end

	//////////////////////////////
	// read path
	always_comb begin
		rd_data = '0;
		case (reg_rd_req.addr)
			`ETS_REG_CHANNEL: rd_data[1:0] = channel;
			`ETS_REG_WINDOW:  rd_data[`ETS_COUNT_W-1:0] = window_len;
			`ETS_REG_STEPS:   rd_data[`ETS_PHASE_W-1:0] = num_steps;
			`ETS_REG_STATUS:  rd_data[$bits(ets_status_t)-1:0] = status; // busy in bit 8
			`ETS_REG_COUNT:   rd_data[`ETS_COUNT_W-1:0] = last_count;
			default: ; // CTRL and holes read zero
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			rsp_valid_q <= 1'b0;
		else
			rsp_valid_q <= reg_rd_req.valid; // fixed one-cycle latency
	end

	always_ff @(posedge sys_clk) begin
		if (reg_rd_req.valid)
			rsp_data_q <= rd_data; // hold last data otherwise
	end

	assign reg_rd_rsp = reg_rd_rsp_t'{valid: rsp_valid_q, data: rsp_data_q};

endmodule

// File: hw/ets_sweep_fsm.sv
`timescale 1ns/1ps
`include "ets_defs.svh"

module ets_sweep_fsm (
	input  logic                      sys_clk,
	input  logic                      rst_n,
	input  logic                      start,
	input  logic [`ETS_PHASE_W-1:0]   num_steps,
	input  logic                      expired,
	input  logic                      tx_ready,
	input  logic                      ps_done,
	output logic                      timer_load,
	output logic                      tx_send,
	output logic                      ps_en,
	output ets_meas_pkg::ets_status_t status
);
	import ets_meas_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WINDOW,    // timer running, counter adding
		S_EMIT,      // hand result to tx, waits on credit
		S_SHIFT,     // one-cycle phase request
		S_WAIT_DONE  // shifter busy
	} state_t;

	state_t                  state;
	state_t                  state_nxt;
	logic [`ETS_PHASE_W-1:0] phase_q; // current step
	logic [`ETS_PHASE_W-1:0] steps_q; // latched at start
	logic                    go;      // accepted start
	logic                    last_step;

	assign go        = (state == S_IDLE) && start && (num_steps != '0);
	assign last_step = (phase_q == steps_q - 1'b1);

	//////////////////////////////
	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:
				if (go)
					state_nxt = S_WINDOW;
			S_WINDOW:
				if (expired)
					state_nxt = S_EMIT; // count is final next cycle
			S_EMIT:
				if (tx_ready)
					state_nxt = last_step ? S_IDLE : S_SHIFT; // no shift after the last step
			S_SHIFT:
				state_nxt = S_WAIT_DONE;
			S_WAIT_DONE:
				if (ps_done)
					state_nxt = S_WINDOW;
			default:
				state_nxt = S_IDLE;
		endcase
	end

	// timer and counter reload at each window start
	assign timer_load = go || ((state == S_WAIT_DONE) && ps_done);
	assign tx_send    = (state == S_EMIT) && tx_ready;
	assign ps_en      = (state == S_SHIFT);
	assign status     = ets_status_t'{busy: state != S_IDLE, phase: phase_q};

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			phase_q <= '0;
			steps_q <= '0;
		end else begin
			state <= state_nxt;
			if ((state == S_IDLE) && start) begin // start while busy is dropped
				phase_q <= '0;
				steps_q <= num_steps;
			end
			if (state == S_SHIFT)
				phase_q <= phase_q + 1'b1; // next step index
		end
	end

endmodule

// File: hw/ets_top.sv
`timescale 1ns/1ps
`include "ets_defs.svh"

module ets_top (
	input  logic                      sys_clk,
	input  logic                      rst_n,
	input  ets_reg_pkg::reg_wr_t      reg_wr,
	input  ets_reg_pkg::reg_rd_req_t  reg_rd_req,
	output ets_reg_pkg::reg_rd_rsp_t  reg_rd_rsp,
	input  logic                      cmp_ref,
	input  logic                      cmp_s11,
	input  logic                      cmp_s21,
	output logic                      ps_en,
	input  logic                      ps_done,
	output logic                      result_valid,
	output ets_meas_pkg::ets_result_t result,
	input  logic                      credit_ret
);
	import ets_meas_pkg::*;

	logic                    start;      // CTRL strobe
	cmp_sel_t                channel;
	logic [`ETS_COUNT_W-1:0] window_len;
	logic [`ETS_PHASE_W-1:0] num_steps;
	ets_status_t             status;
	logic                    timer_load; // also clears the counter
	logic                    active;
	logic                    expired;
	logic                    tx_send;
	logic                    tx_ready;
	logic [`ETS_COUNT_W-1:0] hit_count;

	//////////////////////////////
	// control
	ets_regs i_ets_regs (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.reg_wr     (reg_wr),
		.reg_rd_req (reg_rd_req),
		.reg_rd_rsp (reg_rd_rsp),
		.status     (status),
		.last_count (result.count), // count of the last record sent
		.start      (start),
		.channel    (channel),
		.window_len (window_len),
		.num_steps  (num_steps)
	);

	ets_sweep_fsm i_ets_sweep_fsm (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.start      (start),
		.num_steps  (num_steps),
		.expired    (expired),
		.tx_ready   (tx_ready),
		.ps_done    (ps_done),
		.timer_load (timer_load),
		.tx_send    (tx_send),
		.ps_en      (ps_en),
		.status     (status)
	);

	ets_window_timer i_ets_window_timer (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.load       (timer_load),
		.window_len (window_len),
		.active     (active),
		.expired    (expired)
	);

	//////////////////////////////
	// data path
	ets_hit_counter i_ets_hit_counter (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.cmp_ref   (cmp_ref),
		.cmp_s11   (cmp_s11),
		.cmp_s21   (cmp_s21),
		.channel   (channel),
		.active    (active),
		.load      (timer_load),
		.hit_count (hit_count)
	);

	ets_credit_tx i_ets_credit_tx (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.send         (tx_send),
		.phase        (status.phase), // step being emitted
		.hit_count    (hit_count),
		.credit_ret   (credit_ret),
		.ready        (tx_ready),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

// File: hw/ets_window_timer.sv
`timescale 1ns/1ps
`include "ets_defs.svh"

module ets_window_timer (
	input  logic                    sys_clk,
	input  logic                    rst_n,
	input  logic                    load,
	input  logic [`ETS_COUNT_W-1:0] window_len,
	output logic                    active,
	output logic                    expired
);

	logic [`ETS_COUNT_W-1:0] remain_q; // cycles left incl. this one
	logic                    run_q;

	assign active  = run_q;
	assign expired = run_q && (remain_q == `ETS_COUNT_W'(1)); // last window cycle

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			run_q <= 1'b0;
		else if (load)
			run_q <= 1'b1;
		else if (expired)
			run_q <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (load)
			remain_q <= window_len;
		else if (run_q)
			remain_q <= remain_q - 1'b1;
	end

endmodule

// File: src.f
+incdir+hw
hw/ets_meas_pkg.sv
hw/ets_reg_pkg.sv
hw/ets_regs.sv
hw/ets_sweep_fsm.sv
hw/ets_window_timer.sv
hw/ets_hit_counter.sv
hw/ets_credit_tx.sv
hw/ets_top.sv
verification/ets_clk_gen.sv
verification/ets_asserts.sv
verification/ets_tb.sv

// File: verification/ets_asserts.sv
`timescale 1ns/1ps
`include "ets_defs.svh"

module ets_asserts (
	input logic                                  sys_clk,
	input logic                                  rst_n,
	input logic                                  ps_en,
	input logic                                  ps_done,
	input logic                                  send,
	input logic [$clog2(`ETS_CREDITS + 1)-1:0]   credits
);

	logic pending; // shift requested, done not yet seen

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			pending <= 1'b0;
		else if (ps_en)
			pending <= 1'b1;
		else if (ps_done)
			pending <= 1'b0;
	end

	a_ps_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n) ps_en |=> !ps_en)
		else $error("ps_en longer than one cycle");
	a_ps_wait: assert property (@(posedge sys_clk) disable iff (!rst_n) pending |-> !ps_en)
		else $error("ps_en while shift in flight");
	a_send_credit: assert property (@(posedge sys_clk) disable iff (!rst_n)
		send |-> (credits != 0))
		else $error("send without credit");
	a_credit_max: assert property (@(posedge sys_clk) disable iff (!rst_n)
		credits <= `ETS_CREDITS)
		else $error("credit count above grant");

endmodule

// sweep side, credit checks tied off
bind ets_sweep_fsm ets_asserts i_sweep_asserts (
	.sys_clk (sys_clk),
	.rst_n   (rst_n),
	.ps_en   (ps_en),
	.ps_done (ps_done),
	.send    (1'b0),
	.credits (($clog2(`ETS_CREDITS + 1))'(0))
);

// credit side, shift checks tied off
bind ets_credit_tx ets_asserts i_credit_asserts (
	.sys_clk (sys_clk),
	.rst_n   (rst_n),
	.ps_en   (1'b0),
	.ps_done (1'b0),
	.send    (send),
	.credits (credits)
);

// File: verification/ets_clk_gen.sv
`timescale 1ns/1ps

module ets_clk_gen (
	output logic sys_clk,
	output logic rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk; // 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge sys_clk); // 4 cycles in reset
		#1 rst_n = 1'b1;
	end

endmodule

// File: verification/ets_tb.sv
`timescale 1ns/1ps
`include "ets_defs.svh"

module ets_tb;
	import ets_meas_pkg::*;
	import ets_reg_pkg::*;

	logic        sys_clk, rst_n;
	reg_wr_t     reg_wr;
	reg_rd_req_t reg_rd_req;
	reg_rd_rsp_t reg_rd_rsp;
	logic        cmp_ref, cmp_s11, cmp_s21;
	logic        ps_en, ps_done, result_valid, credit_ret;
	ets_result_t result;

	integer seed = 76829;
	int n_checks = 0, n_errors = 0;
	int sw_ch[4] = '{0, 1, 2, 3};
	int sw_win[4] = '{10, 7, 12, 5};
	int sw_steps[4] = '{5, 6, 4, 7};
	logic lv_ref[256], lv_s11[256], lv_s21[256]; // levels per step
	cmp_sel_t cur_ch;
	logic [15:0] cur_win;
	int cur_steps = 0, res_idx = 0, ps_step = 0, ps_count = 0;
	int outstanding = 0;
	bit ps_pending = 0, bp_hold = 0;
	ets_result_t last_exp;

	ets_clk_gen i_ets_clk_gen (.sys_clk(sys_clk), .rst_n(rst_n));

	ets_top i_ets_top (.*);

	//////////////////////////////
	// reference and compare
	function automatic ets_result_t ref_result(int k, cmp_sel_t ch, logic [15:0] win);
		logic lvl;
		case (ch)
			CMP_S11: lvl = lv_s11[k];
			CMP_S21: lvl = lv_s21[k];
			default: lvl = lv_ref[k]; // codes 0 and 3
		endcase
		return '{phase: 8'(k), count: lvl ? win : 16'h0};
	endfunction

	task automatic check_result(string name, ets_result_t got, ets_result_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("CHECK FAILED %s got 0x%06h exp 0x%06h", name, got, exp);
		end
	endtask

	task automatic check_rsp(string name, reg_rd_rsp_t got, logic [31:0] exp);
		n_checks++;
		if (!got.valid) begin
			n_errors++;
			$display("%s: no read response one cycle after the request", name);
		end else if (got.data !== exp) begin
			n_errors++;
			$display("CHECK FAILED %s got 0x%08h exp 0x%08h", name, got.data, exp);
		end
	endtask

	task automatic apply_levels(int k);
		cmp_ref = lv_ref[k];
		cmp_s11 = lv_s11[k];
		cmp_s21 = lv_s21[k];
	endtask

	//////////////////////////////
	// register port
	task automatic reg_write(logic [2:0] a, logic [31:0] d);
		@(posedge sys_clk) #1 reg_wr = '{valid: 1'b1, addr: a, data: d};
		@(posedge sys_clk) #1 reg_wr.valid = 1'b0;
	endtask

	task automatic reg_read_check(string name, logic [2:0] a, logic [31:0] exp);
		@(posedge sys_clk) #1 reg_rd_req = '{valid: 1'b1, addr: a};
		@(posedge sys_clk) #1 reg_rd_req.valid = 1'b0;
		check_rsp(name, reg_rd_rsp, exp); // response stable now
	endtask

	// phase shifter, answers each ps_en after 3..8 cycles
	always begin
		int d;
		@(negedge sys_clk);
		if (ps_en) begin
			ps_count++;
			d = 3 + ((($random(seed) % 6) + 6) % 6);
			@(posedge sys_clk) #1;
			ps_pending = 1'b1; // shift in flight until ps_done
			ps_step++;
			apply_levels(ps_step); // new step levels
			repeat (d - 1) @(posedge sys_clk);
			#1 ps_done = 1'b1;
			@(posedge sys_clk) #1 ps_done = 1'b0;
			ps_pending = 1'b0;
		end
	end

	// result monitor, compares in order
	always @(negedge sys_clk) begin
		if (result_valid) begin
			outstanding++;
			if (ps_pending) begin
				n_errors++;
				$display("result arrived before the phase shift finished");
			end
			if (res_idx >= cur_steps) begin
				n_errors++;
				$display("extra result beyond the configured step count");
			end else begin
				last_exp = ref_result(res_idx, cur_ch, cur_win);
				check_result("result", result, last_exp);
			end
			res_idx++;
		end
	end

	// credit sink
	always @(posedge sys_clk) begin
		#1 credit_ret = 1'b0;
		if (!bp_hold && outstanding > 0) begin
			credit_ret = 1'b1;
			outstanding--;
		end
	end

	task automatic run_sweep(int ch, int win, int steps, bit hold);
		for (int k = 0; k < steps; k++) begin
			lv_ref[k] = 1'($random(seed));
			lv_s11[k] = 1'($random(seed));
			lv_s21[k] = 1'($random(seed));
		end
		reg_write(`ETS_REG_CHANNEL, 32'(ch));
		reg_write(`ETS_REG_WINDOW, 32'(win));
		reg_write(`ETS_REG_STEPS, 32'(steps));
		cur_ch = cmp_sel_t'(ch);
		cur_win = 16'(win);
		cur_steps = steps;
		res_idx = 0;
		ps_step = 0;
		ps_count = 0;
		bp_hold = hold;
		apply_levels(0);
		reg_write(`ETS_REG_CTRL, 32'h1);
		wait (res_idx >= 1);
		reg_write(`ETS_REG_CTRL, 32'h1); // mid sweep, must be ignored
		if (hold) begin
			wait (outstanding == `ETS_CREDITS);
			repeat (30) @(posedge sys_clk);
			if (res_idx != `ETS_CREDITS) begin
				n_errors++;
				$display("result sent without a credit");
			end
			bp_hold = 0;
		end
		wait (res_idx == steps);
		repeat (20) @(posedge sys_clk); // room for a stray result
		if (ps_count != steps - 1) begin
			n_errors++;
			$display("wrong number of phase shift requests: %0d", ps_count);
		end
		reg_read_check("status", `ETS_REG_STATUS, 32'(steps - 1));
		reg_read_check("count", `ETS_REG_COUNT, 32'(last_exp.count));
	endtask

	//////////////////////////////
	// watchdog
	initial begin
		int budget;
		budget = 2000; // margin for register traffic and back-pressure
		foreach (sw_win[i])
			budget += sw_steps[i] * (sw_win[i] + 20);
		repeat (budget) @(posedge sys_clk);
		$display("timeout, %0d of %0d results seen", res_idx, cur_steps);
		$display("Errors found");
		$finish;
	end

	initial begin
		reg_wr = '0;
		reg_rd_req = '0;
		{cmp_ref, cmp_s11, cmp_s21, ps_done, credit_ret} = '0;
		wait (rst_n);
		reg_write(`ETS_REG_CHANNEL, 32'h2);
		reg_write(`ETS_REG_WINDOW, 32'h1234);
		reg_write(`ETS_REG_STEPS, 32'h5A);
		reg_write(3'd7, 32'hFFFF_FFFF); // hole, ignored
		reg_read_check("channel", `ETS_REG_CHANNEL, 32'h2);
		reg_read_check("window", `ETS_REG_WINDOW, 32'h1234);
		reg_read_check("steps", `ETS_REG_STEPS, 32'h5A);
		reg_read_check("ctrl", `ETS_REG_CTRL, 32'h0);
		reg_read_check("addr6", 3'd6, 32'h0);
		reg_read_check("addr7", 3'd7, 32'h0);
		for (int i = 0; i < 4; i++)
			run_sweep(sw_ch[i], sw_win[i], sw_steps[i], i == 3);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
